//--- alu_config.svh
// width and code macros for the EX stage, included by the package and the RTL files
`ifndef ALU_CONFIG_SVH
`define ALU_CONFIG_SVH

// operand and result width
`define ALU_DATA_WIDTH 32
// memory address width
`define ALU_ADDR_WIDTH 32
// shift amount width, also the divider step count width
`define ALU_SHAMT_WIDTH 5
// register index plus one bit so the empty code fits
`define ALU_RD_WIDTH 6
// destination code for no writeback
`define ALU_RD_NONE 6'd32

`endif

//--- alu_pkg.sv
// shared data types of the EX stage, imported by the RTL units and the testbench
`include "alu_config.svh"

package alu_pkg;

	typedef logic [`ALU_DATA_WIDTH-1:0]  data_t;	// one operand or result word
	typedef logic [`ALU_SHAMT_WIDTH-1:0] shamt_t;	// shift amount
	typedef logic [`ALU_RD_WIDTH-1:0]    rd_t;	// destination field incl. empty code
	typedef logic [`ALU_ADDR_WIDTH-1:0]  addr_t;	// memory address

	// full product of two words, read whole or as two halves
	typedef union packed
	{
		logic [2*`ALU_DATA_WIDTH-1:0] full;	// whole 64-bit product
		struct packed
		{
			data_t hi;	// upper word for mulh variants
			data_t lo;	// lower word for mul
		} half;
	} mul_product_u;

endpackage

//--- alu_logic_unit.sv
// integer add/sub, compares, logic ops, shifts and branch decision of the EX stage
`timescale 1ns/1ns
`include "alu_config.svh"

module alu_logic_unit
(
	input  alu_pkg::data_t src_data1_i,	// source operand 1
	input  alu_pkg::data_t src_data2_i,	// source operand 2
	input  logic           alu_add_i,	// add
	input  logic           alu_sub_i,	// sub, also beq/bne compare
	input  logic           alu_com_i,	// signed set-less-than, also blt/bge
	input  logic           alu_ucom_i,	// unsigned set-less-than, also bltu/bgeu
	input  logic           alu_and_i,	// and
	input  logic           alu_or_i,	// or
	input  logic           alu_xor_i,	// xor
	input  logic           alu_sll_i,	// shift left logical
	input  logic           alu_srl_i,	// shift right logical
	input  logic           alu_sra_i,	// shift right arithmetic
	input  logic           beq_i,	// branch if equal
	input  logic           bne_i,	// branch if not equal
	input  logic           blt_i,	// branch if less, signed
	input  logic           bge_i,	// branch if greater or equal, signed
	input  logic           bltu_i,	// branch if less, unsigned
	input  logic           bgeu_i,	// branch if greater or equal, unsigned
	output alu_pkg::data_t logic_result_o,	// OR of gated results
	output logic           branch_taken_o	// branch condition met
);
	import alu_pkg::*;

	data_t  add_a;	// gated adder input 1
	data_t  add_b;	// gated adder input 2, negated for sub
	data_t  add_result;
	data_t  com_a;	// gated signed compare inputs
	data_t  com_b;
	data_t  ucom_a;	// gated unsigned compare inputs
	data_t  ucom_b;
	logic   com_lt;	// signed a < b
	logic   ucom_lt;	// unsigned a < b
	shamt_t shamt;	// low bits of operand 2
	data_t  and_result;
	data_t  or_result;
	data_t  xor_result;
	data_t  sll_result;
	data_t  srl_result;
	data_t  sra_full;	// sign-filled shift, ungated
	data_t  sra_result;
	logic   sub_zero;	// operands equal

	assign add_a      = (alu_add_i | alu_sub_i) ? src_data1_i : '0;
	assign add_b      = alu_add_i ? src_data2_i : (alu_sub_i ? (~src_data2_i + 1'b1) : '0);
	assign add_result = add_a + add_b;

	assign com_a   = alu_com_i ? src_data1_i : '0;	// 0 < 0 is false when idle
	assign com_b   = alu_com_i ? src_data2_i : '0;
	assign com_lt  = $signed(com_a) < $signed(com_b);
	assign ucom_a  = alu_ucom_i ? src_data1_i : '0;
	assign ucom_b  = alu_ucom_i ? src_data2_i : '0;
	assign ucom_lt = ucom_a < ucom_b;

	assign and_result = alu_and_i ? (src_data1_i & src_data2_i) : '0;
	assign or_result  = alu_or_i ? (src_data1_i | src_data2_i) : '0;
	assign xor_result = alu_xor_i ? (src_data1_i ^ src_data2_i) : '0;

	assign shamt      = src_data2_i[`ALU_SHAMT_WIDTH-1:0];
	assign sll_result = alu_sll_i ? (src_data1_i << shamt) : '0;
	assign srl_result = alu_srl_i ? (src_data1_i >> shamt) : '0;
	// kept apart from the gate so the signed shift keeps its sign fill
	assign sra_full   = $signed(src_data1_i) >>> shamt;
	assign sra_result = alu_sra_i ? sra_full : '0;

	assign logic_result_o = add_result | {{(`ALU_DATA_WIDTH-1){1'b0}}, com_lt}
		| {{(`ALU_DATA_WIDTH-1){1'b0}}, ucom_lt} | and_result | or_result | xor_result
		| sll_result | srl_result | sra_result;

	assign sub_zero = alu_sub_i & ~(|add_result);	// rs1 - rs2 == 0

	assign branch_taken_o = (beq_i & sub_zero)
		| (bne_i & alu_sub_i & ~sub_zero)
		| (blt_i & com_lt)
		| (bge_i & alu_com_i & ~com_lt)
		| (bltu_i & ucom_lt)
		| (bgeu_i & alu_ucom_i & ~ucom_lt);

endmodule

//--- alu_mul_unit.sv
// combinational RV32M multiplier for mul, mulh, mulhsu and mulhu, used by the EX stage
`timescale 1ns/1ns
`include "alu_config.svh"

module alu_mul_unit
(
	input  alu_pkg::data_t src_data1_i,	// multiplicand
	input  alu_pkg::data_t src_data2_i,	// multiplier
	input  logic           alu_mul_i,	// low word, signed x signed
	input  logic           alu_mulh_i,	// high word, signed x signed
	input  logic           alu_mulhsu_i,	// high word, signed x unsigned
	input  logic           alu_mulhu_i,	// high word, unsigned x unsigned
	output alu_pkg::data_t mul_result_o	// selected half, zero when idle
);
	import alu_pkg::*;

	logic         neg1;	// operand 1 treated as negative
	logic         neg2;	// operand 2 treated as negative
	data_t        mag1;	// magnitude of operand 1
	data_t        mag2;	// magnitude of operand 2
	mul_product_u prod_mag;	// unsigned product of magnitudes
	mul_product_u prod;	// product with sign applied
	logic         sel_hi;	// any high-word variant

	assign neg1 = (alu_mul_i | alu_mulh_i | alu_mulhsu_i) & src_data1_i[`ALU_DATA_WIDTH-1];
	assign neg2 = (alu_mul_i | alu_mulh_i) & src_data2_i[`ALU_DATA_WIDTH-1];

	// most negative value maps to 2^31, which still fits unsigned
	assign mag1 = neg1 ? -src_data1_i : src_data1_i;
	assign mag2 = neg2 ? -src_data2_i : src_data2_i;

	assign prod_mag.full = {{`ALU_DATA_WIDTH{1'b0}}, mag1} * {{`ALU_DATA_WIDTH{1'b0}}, mag2};
	assign prod.full     = (neg1 ^ neg2) ? -prod_mag.full : prod_mag.full;	// negate whole word

	assign sel_hi = alu_mulh_i | alu_mulhsu_i | alu_mulhu_i;

	assign mul_result_o = ({`ALU_DATA_WIDTH{alu_mul_i}} & prod.half.lo)
		| ({`ALU_DATA_WIDTH{sel_hi}} & prod.half.hi);

endmodule

//--- div_serial.sv
// unsigned radix-2 restoring divider, 32 steps per operation, used by the divide unit
`timescale 1ns/1ns
`include "alu_config.svh"

module div_serial
(
	input  logic           cpu_clk,	// cpu clock
	input  logic           cpu_rstn,	// async reset, active low
	input  logic           start_i,	// start level, sampled while idle
	input  alu_pkg::data_t dividend_i,	// unsigned dividend
	input  alu_pkg::data_t divisor_i,	// unsigned divisor
	output logic           done_o,	// one-cycle completion pulse
	output alu_pkg::data_t quotient_o,	// held until the next start
	output alu_pkg::data_t remainder_o	// held until the next start
);
	import alu_pkg::*;

	logic                        busy_q;	// iterations in progress
	logic [`ALU_SHAMT_WIDTH-1:0] step_q;	// current step 0..31
	logic                        start_go;	// start accepted this cycle
	data_t                       divisor_q;	// sampled divisor
	data_t                       quo_q;	// dividend bits shift out, quotient bits shift in
	data_t                       rem_q;	// partial remainder
	logic [`ALU_DATA_WIDTH:0]    rem_shift;	// remainder with next dividend bit
	logic [`ALU_DATA_WIDTH:0]    trial;	// trial subtraction, msb is borrow

	// the done cycle is not idle, or a strobe still held would restart
	assign start_go  = start_i & ~busy_q & ~done_o;
	assign rem_shift = {rem_q, quo_q[`ALU_DATA_WIDTH-1]};
	assign trial     = rem_shift - {1'b0, divisor_q};

	always_ff @(posedge cpu_clk or negedge cpu_rstn)
	begin
		if (!cpu_rstn)
		begin
			busy_q <= 1'b0;
			step_q <= '0;
			done_o <= 1'b0;
		end
		else
		begin
			done_o <= 1'b0;	// pulse by default
			if (start_go)
			begin
				busy_q <= 1'b1;
				step_q <= '0;
			end
			else if (busy_q)
			begin
				step_q <= step_q + 1'b1;
				if (&step_q)	// last step
				begin
					busy_q <= 1'b0;
					done_o <= 1'b1;
				end
			end
		end
	end

	always_ff @(posedge cpu_clk)
	begin
		if (start_go)
		begin
			divisor_q <= divisor_i;
			quo_q     <= dividend_i;
			rem_q     <= '0;
		end
		else if (busy_q)
		begin
			// restore on borrow, else keep the difference
			rem_q <= trial[`ALU_DATA_WIDTH] ? rem_shift[`ALU_DATA_WIDTH-1:0]
				: trial[`ALU_DATA_WIDTH-1:0];
			quo_q <= {quo_q[`ALU_DATA_WIDTH-2:0], ~trial[`ALU_DATA_WIDTH]};
		end
	end

	assign quotient_o  = quo_q;	// zero divisor never borrows, giving all ones
	assign remainder_o = rem_q;	// and the dividend as remainder

endmodule

//--- alu_div_unit.sv
// RV32M divide and remainder with sign handling around the serial divider, stalls the EX stage
`timescale 1ns/1ns
`include "alu_config.svh"

module alu_div_unit
(
	input  logic           cpu_clk,	// cpu clock
	input  logic           cpu_rstn,	// async reset, active low
	input  alu_pkg::data_t src_data1_i,	// dividend
	input  alu_pkg::data_t src_data2_i,	// divisor
	input  logic           alu_div_i,	// signed quotient
	input  logic           alu_divu_i,	// unsigned quotient
	input  logic           alu_rem_i,	// signed remainder
	input  logic           alu_remu_i,	// unsigned remainder
	output alu_pkg::data_t div_result_o,	// selected result, zero when idle
	output logic           div_stall_o	// divide requested and not done
);
	import alu_pkg::*;

	logic  use_s;	// signed variant
	logic  div_start;	// any divide strobe
	logic  div_done;
	logic  sign1;	// dividend sign
	logic  sign_diff;	// quotient needs negation
	data_t dividend;	// magnitude or raw dividend
	data_t divisor;	// magnitude or raw divisor
	data_t quotient;
	data_t remainder;
	data_t quo_signed;
	data_t rem_signed;

	assign use_s     = alu_div_i | alu_rem_i;
	assign div_start = use_s | alu_divu_i | alu_remu_i;
	assign sign1     = src_data1_i[`ALU_DATA_WIDTH-1];

	assign dividend = (use_s & sign1) ? -src_data1_i : src_data1_i;
	assign divisor  = (use_s & src_data2_i[`ALU_DATA_WIDTH-1]) ? -src_data2_i : src_data2_i;

	div_serial u_div_serial
	(
		.cpu_clk     (cpu_clk),
		.cpu_rstn    (cpu_rstn),
		.start_i     (div_start),
		.dividend_i  (dividend),
		.divisor_i   (divisor),
		.done_o      (div_done),
		.quotient_o  (quotient),
		.remainder_o (remainder)
	);

	// zero divisor keeps all ones, -2^31 / -1 keeps 2^31 unchanged
	assign sign_diff  = (|src_data2_i) & (sign1 ^ src_data2_i[`ALU_DATA_WIDTH-1]);
	assign quo_signed = sign_diff ? -quotient : quotient;
	assign rem_signed = sign1 ? -remainder : remainder;	// remainder follows dividend sign

	assign div_result_o = ({`ALU_DATA_WIDTH{alu_div_i}} & quo_signed)
		| ({`ALU_DATA_WIDTH{alu_divu_i}} & quotient)
		| ({`ALU_DATA_WIDTH{alu_rem_i}} & rem_signed)
		| ({`ALU_DATA_WIDTH{alu_remu_i}} & remainder);

	assign div_stall_o = div_start & ~div_done;

endmodule

//--- ex_mem_reg.sv
// EX-to-MEM pipeline register with bubble insertion and hold on MEM back-pressure
`timescale 1ns/1ns
`include "alu_config.svh"

module ex_mem_reg
(
	input  logic           cpu_clk,	// cpu clock
	input  logic           cpu_rstn,	// async reset, active low
	input  logic           load_en_i,	// instruction valid and not stalled, else bubble
	input  logic           mem_ready_i,	// MEM stage accepts
	input  alu_pkg::data_t result_i,	// forwarded EX result
	input  alu_pkg::rd_t   rd_i,	// destination at EX
	input  logic           load_i,	// load instruction
	input  logic           store_i,	// store instruction
	input  logic           mem_h_i,	// halfword access
	input  logic           mem_b_i,	// byte access
	input  logic           mem_u_i,	// unsigned load
	input  alu_pkg::data_t store_data_i,	// store source data
	output logic           ex_valid_o,	// MEM outputs valid
	output alu_pkg::data_t alu_result_mem_o,	// result at MEM
	output alu_pkg::rd_t   rd_mem_o,	// destination at MEM
	output logic           load_mem_o,	// load at MEM
	output logic           store_mem_o,	// store at MEM
	output logic           mem_h_mem_o,	// halfword at MEM
	output logic           mem_b_mem_o,	// byte at MEM
	output logic           mem_u_mem_o,	// unsigned load at MEM
	output alu_pkg::data_t store_data_mem_o,	// store data at MEM
	output alu_pkg::addr_t mem_addr_o	// address for loads and stores, else 0
);

	// control fields
	always_ff @(posedge cpu_clk or negedge cpu_rstn)
	begin
		if (!cpu_rstn)
		begin
			ex_valid_o  <= 1'b0;
			rd_mem_o    <= `ALU_RD_NONE;
			load_mem_o  <= 1'b0;
			store_mem_o <= 1'b0;
			mem_h_mem_o <= 1'b0;
			mem_b_mem_o <= 1'b0;
			mem_u_mem_o <= 1'b0;
		end
		else if (mem_ready_i)	// hold everything under back-pressure
		begin
			ex_valid_o  <= 1'b1;
			rd_mem_o    <= load_en_i ? rd_i : `ALU_RD_NONE;	// bubble writes nothing back
			load_mem_o  <= load_en_i & load_i;
			store_mem_o <= load_en_i & store_i;
			mem_h_mem_o <= load_en_i & mem_h_i;
			mem_b_mem_o <= load_en_i & mem_b_i;
			mem_u_mem_o <= load_en_i & mem_u_i;
		end
	end

	// data fields
	always_ff @(posedge cpu_clk)
	begin
		if (mem_ready_i)
		begin
			alu_result_mem_o <= load_en_i ? result_i : '0;
			store_data_mem_o <= load_en_i ? store_data_i : '0;
		end
	end

	assign mem_addr_o = (load_mem_o | store_mem_o) ? alu_result_mem_o : '0;

endmodule

//--- alu_ex_stage.sv
// EX stage top of the RV32IM pipeline, merges unit results and drives the EX-to-MEM register
`timescale 1ns/1ns

module alu_ex_stage
(
	input  logic           cpu_clk,	// cpu clock
	input  logic           cpu_rstn,	// async reset, active low
	input  logic           dec_valid_i,	// decode has an instruction
	output logic           ex_ready_o,	// EX can accept
	input  logic           mem_ready_i,	// MEM can accept
	input  alu_pkg::data_t src_data1_i,	// source operand 1
	input  alu_pkg::data_t src_data2_i,	// source operand 2
	input  logic           only_src2_used_i,	// lui bypass
	input  logic           alu_add_i,
	input  logic           alu_sub_i,
	input  logic           alu_com_i,
	input  logic           alu_ucom_i,
	input  logic           alu_and_i,
	input  logic           alu_or_i,
	input  logic           alu_xor_i,
	input  logic           alu_sll_i,
	input  logic           alu_srl_i,
	input  logic           alu_sra_i,
	input  logic           alu_mul_i,
	input  logic           alu_mulh_i,
	input  logic           alu_mulhsu_i,
	input  logic           alu_mulhu_i,
	input  logic           alu_div_i,
	input  logic           alu_divu_i,
	input  logic           alu_rem_i,
	input  logic           alu_remu_i,
	input  logic           beq_i,
	input  logic           bne_i,
	input  logic           blt_i,
	input  logic           bge_i,
	input  logic           bltu_i,
	input  logic           bgeu_i,
	input  logic           load_i,	// load instruction
	input  logic           store_i,	// store instruction
	input  logic           mem_h_i,	// halfword access
	input  logic           mem_b_i,	// byte access
	input  logic           mem_u_i,	// unsigned load
	input  alu_pkg::data_t store_data_i,	// store source data
	input  alu_pkg::rd_t   rd_i,	// destination at EX
	output alu_pkg::data_t alu_result_o,	// forwarded to decode, same cycle
	output logic           branch_taken_o,	// branch condition met
	output logic           ex_valid_o,
	output alu_pkg::data_t alu_result_mem_o,
	output alu_pkg::rd_t   rd_mem_o,
	output logic           load_mem_o,
	output logic           store_mem_o,
	output logic           mem_h_mem_o,
	output logic           mem_b_mem_o,
	output logic           mem_u_mem_o,
	output alu_pkg::data_t store_data_mem_o,
	output alu_pkg::addr_t mem_addr_o
);
	import alu_pkg::*;

	data_t logic_result;	// base integer result
	data_t mul_result;	// multiply result
	data_t div_result;	// divide/remainder result
	logic  ex_stall;	// divide in progress
	logic  load_en;	// take the instruction, else bubble

	alu_logic_unit u_alu_logic_unit
	(
		.src_data1_i    (src_data1_i),
		.src_data2_i    (src_data2_i),
		.alu_add_i      (alu_add_i),
		.alu_sub_i      (alu_sub_i),
		.alu_com_i      (alu_com_i),
		.alu_ucom_i     (alu_ucom_i),
		.alu_and_i      (alu_and_i),
		.alu_or_i       (alu_or_i),
		.alu_xor_i      (alu_xor_i),
		.alu_sll_i      (alu_sll_i),
		.alu_srl_i      (alu_srl_i),
		.alu_sra_i      (alu_sra_i),
		.beq_i          (beq_i),
		.bne_i          (bne_i),
		.blt_i          (blt_i),
		.bge_i          (bge_i),
		.bltu_i         (bltu_i),
		.bgeu_i         (bgeu_i),
		.logic_result_o (logic_result),
		.branch_taken_o (branch_taken_o)
	);

	alu_mul_unit u_alu_mul_unit
	(
		.src_data1_i  (src_data1_i),
		.src_data2_i  (src_data2_i),
		.alu_mul_i    (alu_mul_i),
		.alu_mulh_i   (alu_mulh_i),
		.alu_mulhsu_i (alu_mulhsu_i),
		.alu_mulhu_i  (alu_mulhu_i),
		.mul_result_o (mul_result)
	);

	alu_div_unit u_alu_div_unit
	(
		.cpu_clk      (cpu_clk),
		.cpu_rstn     (cpu_rstn),
		.src_data1_i  (src_data1_i),
		.src_data2_i  (src_data2_i),
		.alu_div_i    (alu_div_i),
		.alu_divu_i   (alu_divu_i),
		.alu_rem_i    (alu_rem_i),
		.alu_remu_i   (alu_remu_i),
		.div_result_o (div_result),
		.div_stall_o  (ex_stall)
	);

	// every unit gives zero when idle, so OR merges them
	assign alu_result_o = only_src2_used_i ? src_data2_i : (logic_result | mul_result | div_result);

	assign ex_ready_o = ~ex_stall & mem_ready_i;
	assign load_en    = dec_valid_i & ~ex_stall;

	ex_mem_reg u_ex_mem_reg
	(
		.cpu_clk          (cpu_clk),
		.cpu_rstn         (cpu_rstn),
		.load_en_i        (load_en),
		.mem_ready_i      (mem_ready_i),
		.result_i         (alu_result_o),
		.rd_i             (rd_i),
		.load_i           (load_i),
		.store_i          (store_i),
		.mem_h_i          (mem_h_i),
		.mem_b_i          (mem_b_i),
		.mem_u_i          (mem_u_i),
		.store_data_i     (store_data_i),
		.ex_valid_o       (ex_valid_o),
		.alu_result_mem_o (alu_result_mem_o),
		.rd_mem_o         (rd_mem_o),
		.load_mem_o       (load_mem_o),
		.store_mem_o      (store_mem_o),
		.mem_h_mem_o      (mem_h_mem_o),
		.mem_b_mem_o      (mem_b_mem_o),
		.mem_u_mem_o      (mem_u_mem_o),
		.store_data_mem_o (store_data_mem_o),
		.mem_addr_o       (mem_addr_o)
	);

endmodule

//--- tb_alu_ex_stage.sv
// directed testbench for the EX stage, built from sim.f and run through the Makefile
`timescale 1ns/1ns
`include "alu_config.svh"

module tb_alu_ex_stage;
	import alu_pkg::*;

	localparam data_t MOST_NEG = 32'h8000_0000;

	logic        cpu_clk;
	logic        cpu_rstn;
	logic        dec_valid;
	logic        mem_ready;
	data_t       src1;
	data_t       src2;
	logic        only_src2;	// lui bypass
	// bit 0 add, then sub slt sltu and or xor sll srl sra mul mulh mulhsu mulhu div divu rem remu
	logic [17:0] op_vec;
	logic [5:0]  br_vec;	// beq bne blt bge bltu bgeu from bit 0
	logic        load;
	logic        store;
	logic        mem_h;
	logic        mem_b;
	logic        mem_u;
	data_t       store_data;
	rd_t         rd;
	logic        ex_ready;
	data_t       alu_result;
	logic        branch_taken;
	logic        ex_valid;
	data_t       alu_result_mem;
	rd_t         rd_mem;
	logic        load_mem;
	logic        store_mem;
	logic        mem_h_mem;
	logic        mem_b_mem;
	logic        mem_u_mem;
	data_t       store_data_mem;
	addr_t       mem_addr;
	integer      seed;
	int          cycle_cnt = 0;

	alu_ex_stage u_alu_ex_stage
	(
		.cpu_clk          (cpu_clk),
		.cpu_rstn         (cpu_rstn),
		.dec_valid_i      (dec_valid),
		.ex_ready_o       (ex_ready),
		.mem_ready_i      (mem_ready),
		.src_data1_i      (src1),
		.src_data2_i      (src2),
		.only_src2_used_i (only_src2),
		.alu_add_i        (op_vec[0]),
		.alu_sub_i        (op_vec[1]),
		.alu_com_i        (op_vec[2]),
		.alu_ucom_i       (op_vec[3]),
		.alu_and_i        (op_vec[4]),
		.alu_or_i         (op_vec[5]),
		.alu_xor_i        (op_vec[6]),
		.alu_sll_i        (op_vec[7]),
		.alu_srl_i        (op_vec[8]),
		.alu_sra_i        (op_vec[9]),
		.alu_mul_i        (op_vec[10]),
		.alu_mulh_i       (op_vec[11]),
		.alu_mulhsu_i     (op_vec[12]),
		.alu_mulhu_i      (op_vec[13]),
		.alu_div_i        (op_vec[14]),
		.alu_divu_i       (op_vec[15]),
		.alu_rem_i        (op_vec[16]),
		.alu_remu_i       (op_vec[17]),
		.beq_i            (br_vec[0]),
		.bne_i            (br_vec[1]),
		.blt_i            (br_vec[2]),
		.bge_i            (br_vec[3]),
		.bltu_i           (br_vec[4]),
		.bgeu_i           (br_vec[5]),
		.load_i           (load),
		.store_i          (store),
		.mem_h_i          (mem_h),
		.mem_b_i          (mem_b),
		.mem_u_i          (mem_u),
		.store_data_i     (store_data),
		.rd_i             (rd),
		.alu_result_o     (alu_result),
		.branch_taken_o   (branch_taken),
		.ex_valid_o       (ex_valid),
		.alu_result_mem_o (alu_result_mem),
		.rd_mem_o         (rd_mem),
		.load_mem_o       (load_mem),
		.store_mem_o      (store_mem),
		.mem_h_mem_o      (mem_h_mem),
		.mem_b_mem_o      (mem_b_mem),
		.mem_u_mem_o      (mem_u_mem),
		.store_data_mem_o (store_data_mem),
		.mem_addr_o       (mem_addr)
	);

	initial cpu_clk = 1'b0;
	always #20 cpu_clk = ~cpu_clk;	// 40 ns period

	// under 600 ops, about 80 of them divides near 35 cycles, so 20000 is ample
	always @(posedge cpu_clk)
	begin
		cycle_cnt = cycle_cnt + 1;
		if (cycle_cnt >= 20000)
			abort_run("run timed out before all tests finished");
	end

	task automatic abort_run(input string why);
		$display("TEST FAILED");
		$fatal(1, "%s", why);
	endtask

	task automatic check_data(input string name, input data_t got, input data_t exp);
		if (got !== exp)
		begin
			$display("MISMATCH at %0t ns: %s got %h expected %h", $time, name, got, exp);
			abort_run("data compare failed");
		end
	endtask

	task automatic check_rd(input string name, input rd_t got, input rd_t exp);
		if (got !== exp)
		begin
			$display("MISMATCH at %0t ns: %s got %0d expected %0d", $time, name, got, exp);
			abort_run("destination compare failed");
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp)
		begin
			$display("MISMATCH at %0t ns: %s got %b expected %b", $time, name, got, exp);
			abort_run("flag compare failed");
		end
	endtask

	function automatic data_t corner_value(input int k);
		case (k)
			0: return 32'h0000_0000;
			1: return 32'hffff_ffff;	// -1
			2: return MOST_NEG;
			default: return 32'h0000_0001;
		endcase
	endfunction

	function automatic data_t pick_operand();
		data_t r;
		r = $random(seed);
		if (r % 16 < 4)	// a quarter of draws land on a corner
			r = corner_value(r % 4);
		return r;
	endfunction

	// RV32IM result by the ISA rules, op numbered as the bits of op_vec, 18 is lui
	function automatic data_t model_result(input int op, input data_t a, input data_t b);
		int           sa;
		int           sb;
		mul_product_u prod;
		sa        = a;
		sb        = b;
		prod.full = longint'(sa) * longint'(sb);	// signed x signed
		case (op)
			0: return a + b;
			1: return a - b;
			2: return (sa < sb) ? 32'd1 : 32'd0;	// slt
			3: return (a < b) ? 32'd1 : 32'd0;	// sltu
			4: return a & b;
			5: return a | b;
			6: return a ^ b;
			7: return a << b[4:0];
			8: return a >> b[4:0];
			9: return sa >>> b[4:0];	// sign fill
			10: return prod.half.lo;	// mul
			11: return prod.half.hi;	// mulh
			12:	// mulhsu
			begin
				prod.full = longint'(sa) * longint'({32'd0, b});
				return prod.half.hi;
			end
			13:	// mulhu
			begin
				prod.full = {32'd0, a} * {32'd0, b};
				return prod.half.hi;
			end
			14:	// div, rounds toward zero
			begin
				if (b == '0)
					return '1;
				if (a == MOST_NEG && b == '1)
					return a;
				return sa / sb;
			end
			15: return (b == '0) ? '1 : a / b;	// divu
			16:	// rem takes the dividend's sign
			begin
				if (b == '0)
					return a;
				if (a == MOST_NEG && b == '1)
					return '0;
				return sa % sb;
			end
			17: return (b == '0) ? a : a % b;	// remu
			default: return b;	// lui passes source 2
		endcase
	endfunction

	function automatic logic model_branch(input int br, input data_t a, input data_t b);
		int sa;
		int sb;
		sa = a;
		sb = b;
		case (br)
			0: return a == b;
			1: return a != b;
			2: return sa < sb;
			3: return sa >= sb;
			4: return a < b;
			5: return a >= b;
			default: return 1'b0;	// no branch strobe
		endcase
	endfunction

	task automatic set_attrs(input logic ld, input logic st, input logic h, input logic b,
		input logic u);
		load  = ld;
		store = st;
		mem_h = h;
		mem_b = b;
		mem_u = u;
	endtask

	task automatic check_attrs(input logic ld, input logic st, input logic h, input logic b,
		input logic u);
		check_bit("load_mem_o", load_mem, ld);
		check_bit("store_mem_o", store_mem, st);
		check_bit("mem_h_mem_o", mem_h_mem, h);
		check_bit("mem_b_mem_o", mem_b_mem, b);
		check_bit("mem_u_mem_o", mem_u_mem, u);
	endtask

	// called at a falling edge, checks the op in EX and one clock after acceptance in MEM
	task automatic run_op(input int op, input int br, input data_t a, input data_t b);
		data_t exp;
		data_t tmp;
		rd_t   rdv;
		int    waited;
		exp       = model_result(op, a, b);
		tmp       = $random(seed);
		rdv       = {1'b0, tmp[4:0]};	// x0..x31, never the empty code
		dec_valid = 1'b1;
		src1      = a;
		src2      = b;
		only_src2 = (op == 18);
		op_vec    = 18'd1 << op;	// lui leaves every strobe low
		br_vec    = (br < 0) ? 6'd0 : (6'd1 << br);
		rd        = rdv;
		#10;
		check_bit("ex_ready_o", ex_ready, (op < 14 || op > 17));	// divides stall first
		waited = 0;
		while (ex_ready !== 1'b1)
		begin
			@(negedge cpu_clk);
			#10;
			waited++;
			if (waited > 40)
				abort_run("ex_ready_o stayed low for more than 40 cycles on a divide");
		end
		check_data("alu_result_o", alu_result, exp);
		check_bit("branch_taken_o", branch_taken, model_branch(br, a, b));
		@(negedge cpu_clk);
		check_bit("ex_valid_o", ex_valid, 1'b1);
		check_data("alu_result_mem_o", alu_result_mem, exp);
		check_rd("rd_mem_o", rd_mem, rdv);
	endtask

	task automatic sweep_ops(input int first, input int last, input int n_random);
		for (int op = first; op <= last; op++)
		begin
			for (int i = 0; i < 16; i++)
				run_op(op, -1, corner_value(i / 4), corner_value(i % 4));
			repeat (n_random)
				run_op(op, -1, pick_operand(), pick_operand());
		end
	endtask

	task automatic test_reset();
		@(posedge cpu_clk);	// first edge seen with reset low
		repeat (4)
		begin
			@(negedge cpu_clk);
			check_bit("ex_valid_o", ex_valid, 1'b0);
			check_attrs(1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
			check_rd("rd_mem_o", rd_mem, `ALU_RD_NONE);
		end
		cpu_rstn = 1'b1;
		#10;
		check_bit("ex_valid_o", ex_valid, 1'b0);	// nothing loaded before the next edge
		check_bit("load_mem_o", load_mem, 1'b0);
		check_bit("store_mem_o", store_mem, 1'b0);
		check_rd("rd_mem_o", rd_mem, `ALU_RD_NONE);
		@(negedge cpu_clk);
	endtask

	task automatic test_base_ops();
		sweep_ops(0, 9, 4);
		sweep_ops(18, 18, 4);	// lui
	endtask

	task automatic test_branches();
		data_t a;
		for (int br = 0; br < 6; br++)
		begin
			for (int i = 0; i < 16; i++)	// equal, less and greater both ways
				run_op(1 + br / 2, br, corner_value(i / 4), corner_value(i % 4));
			repeat (2)
			begin
				a = pick_operand();
				run_op(1 + br / 2, br, a, a);
				run_op(1 + br / 2, br, a, pick_operand());
			end
		end
	endtask

	task automatic test_multiplies();
		sweep_ops(10, 13, 4);
	endtask

	task automatic test_divides();
		sweep_ops(14, 17, 4);
	endtask

	task automatic test_pipe_reg();
		data_t a;
		data_t b;
		data_t sd;
		data_t held;
		a          = pick_operand();
		b          = pick_operand();
		sd         = $random(seed);
		op_vec     = 18'd1;	// add forms the address
		br_vec     = '0;
		only_src2  = 1'b0;
		src1       = a;
		src2       = b;
		store_data = sd;
		rd         = 6'd7;
		dec_valid  = 1'b0;	// bubble even with load set
		set_attrs(1'b1, 1'b0, 1'b1, 1'b0, 1'b1);
		@(negedge cpu_clk);
		check_bit("ex_valid_o", ex_valid, 1'b1);
		check_rd("rd_mem_o", rd_mem, `ALU_RD_NONE);
		check_data("alu_result_mem_o", alu_result_mem, '0);
		check_data("store_data_mem_o", store_data_mem, '0);
		check_attrs(1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
		check_data("mem_addr_o", mem_addr, '0);
		dec_valid = 1'b1;	// halfword unsigned load
		@(negedge cpu_clk);
		check_rd("rd_mem_o", rd_mem, 6'd7);
		check_attrs(1'b1, 1'b0, 1'b1, 1'b0, 1'b1);
		check_data("mem_addr_o", mem_addr, model_result(0, a, b));
		set_attrs(1'b0, 1'b1, 1'b0, 1'b1, 1'b0);	// byte store
		@(negedge cpu_clk);
		check_attrs(1'b0, 1'b1, 1'b0, 1'b1, 1'b0);
		check_data("store_data_mem_o", store_data_mem, sd);
		check_data("mem_addr_o", mem_addr, model_result(0, a, b));
		set_attrs(1'b0, 1'b0, 1'b0, 1'b0, 1'b0);	// plain add
		@(negedge cpu_clk);
		check_data("alu_result_mem_o", alu_result_mem, model_result(0, a, b));
		check_data("mem_addr_o", mem_addr, '0);
		set_attrs(1'b0, 1'b1, 1'b0, 1'b0, 1'b0);	// word store reaches MEM, then MEM stalls
		@(negedge cpu_clk);
		held       = model_result(0, a, b);
		mem_ready  = 1'b0;
		src1       = ~a;	// a load waits at EX meanwhile
		store_data = ~sd;
		rd         = 6'd11;
		set_attrs(1'b1, 1'b0, 1'b0, 1'b0, 1'b0);
		repeat (5)
		begin
			#10;
			check_bit("ex_ready_o", ex_ready, 1'b0);
			@(negedge cpu_clk);
			check_bit("ex_valid_o", ex_valid, 1'b1);
			check_attrs(1'b0, 1'b1, 1'b0, 1'b0, 1'b0);
			check_data("alu_result_mem_o", alu_result_mem, held);
			check_data("store_data_mem_o", store_data_mem, sd);
			check_data("mem_addr_o", mem_addr, held);
			check_rd("rd_mem_o", rd_mem, 6'd7);
		end
		mem_ready = 1'b1;
		@(negedge cpu_clk);
		check_attrs(1'b1, 1'b0, 1'b0, 1'b0, 1'b0);
		check_data("mem_addr_o", mem_addr, model_result(0, ~a, b));
		check_data("store_data_mem_o", store_data_mem, ~sd);
		check_rd("rd_mem_o", rd_mem, 6'd11);
		dec_valid = 1'b0;
		set_attrs(1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
	endtask

	initial
	begin
		seed       = 84728;
		cpu_rstn   = 1'b0;
		dec_valid  = 1'b0;
		mem_ready  = 1'b1;
		src1       = '0;
		src2       = '0;
		only_src2  = 1'b0;
		op_vec     = '0;
		br_vec     = '0;
		store_data = '0;
		rd         = '0;
		set_attrs(1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
		test_reset();
		test_base_ops();
		test_branches();
		test_multiplies();
		test_divides();
		test_pipe_reg();
		$display("TEST OK");
		$finish;
	end

endmodule

//--- sim.f
+incdir+.
alu_pkg.sv
alu_logic_unit.sv
alu_mul_unit.sv
div_serial.sv
alu_div_unit.sv
ex_mem_reg.sv
alu_ex_stage.sv
tb_alu_ex_stage.sv

//--- Makefile
VERILATOR  := verilator
TOP        := tb_alu_ex_stage
FILELIST   := sim.f
OBJ_DIR    := obj_dir
SIM_FLAGS  := --binary --timing -j 0 --Mdir $(OBJ_DIR)
LINT_FLAGS := --lint-only --timing -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
